/* project.f */
hw/audio_pkg.sv
hw/i2s_pkg.sv
hw/pcm_frame_if.sv
hw/i2s_receiver.sv
hw/frame_fifo.sv
hw/fir_filter.sv
hw/i2s_transmitter.sv
hw/audio_processor.sv
sim/tb_audio_processor.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_audio_processor
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_audio_processor.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_audio_processor
    import audio_pkg::*;
    import i2s_pkg::*;
();

    localparam int NUM_TAPS   = 16;
    localparam int FIFO_DEPTH = 4;
    localparam int BCLK_DIV   = 2;
    localparam int CAW        = $clog2(NUM_TAPS);

    logic           clk;
    logic           rst_n;
    logic           bypass;
    logic           i2s_bclk;
    logic           i2s_lrclk;
    logic           i2s_d;
    logic           coef_we;
    logic [CAW-1:0] coef_addr;
    coef_t          coef_wdata;
    logic           dac_rst;
    logic           dac_bclk;
    logic           dac_lrclk;
    logic           dac_data;
    logic           overflow;

    int          errors = 0;
    int          checks = 0;
    int          in_half = 3;                      // input bclk half period, clk cycles
    logic [31:0] lcg_state = 32'h2592cd14;

    coef_t   m_coef [NUM_TAPS];                    // reference model state
    sample_t m_dly_l [NUM_TAPS];
    sample_t m_dly_r [NUM_TAPS];
    sample_t exp_l [$];                            // expected nonzero frames
    sample_t exp_r [$];
    sample_t rx_l [$];                             // decoded nonzero frames
    sample_t rx_r [$];

    logic    dec_lr;                               // dac decoder state
    int      dec_cnt;
    sample_t dec_sr;
    sample_t dec_l;

    audio_processor #(
        .NUM_TAPS   (NUM_TAPS),
        .FIFO_DEPTH (FIFO_DEPTH),
        .BCLK_DIV   (BCLK_DIV)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .bypass     (bypass),
        .i2s_bclk   (i2s_bclk),
        .i2s_lrclk  (i2s_lrclk),
        .i2s_d      (i2s_d),
        .coef_we    (coef_we),
        .coef_addr  (coef_addr),
        .coef_wdata (coef_wdata),
        .dac_rst    (dac_rst),
        .dac_bclk   (dac_bclk),
        .dac_lrclk  (dac_lrclk),
        .dac_data   (dac_data),
        .overflow   (overflow)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;                         // 20 ns period

    //////////////////////////////
    // dac decoder
    //////////////////////////////
    always @(posedge dac_bclk) begin
        if (dac_lrclk != dec_lr) begin             // slot edge, msb comes next bit
            if (dac_lrclk) begin
                dec_l = dec_sr;
            end else if (dec_l != '0 || dec_sr != '0) begin
                rx_l.push_back(dec_l);             // silence frames dropped
                rx_r.push_back(dec_sr);
            end
            dec_cnt = 0;
        end else if (dec_cnt < DATA_BITS) begin
            dec_sr = {dec_sr[DATA_BITS-2:0], dac_data};
            dec_cnt++;
        end
        dec_lr = dac_lrclk;
    end

    //////////////////////////////
    // checks and helpers
    //////////////////////////////
    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic lcg_frame(output sample_t l, output sample_t r);
        logic [31:0] v;
        v = lcg_next();
        l = v[31:8];                               // upper bits, better spread
        v = lcg_next();
        r = v[31:8];
        if (l == '0 && r == '0) l = 24'sd1;        // never all silence
    endtask

    task automatic lcg_coefs();
        logic [31:0] v;
        for (int k = 0; k < NUM_TAPS; k++) begin
            v = lcg_next();
            m_coef[k] = v[31:16];
        end
    endtask

    // sum of coef k times sample k frames back, or a copy in bypass
    task automatic model_step(input sample_t l, input sample_t r);
        logic signed [63:0] acc_l;
        logic signed [63:0] acc_r;
        for (int k = NUM_TAPS - 1; k > 0; k--) begin
            m_dly_l[k] = m_dly_l[k-1];
            m_dly_r[k] = m_dly_r[k-1];
        end
        m_dly_l[0] = l;
        m_dly_r[0] = r;
        acc_l = '0;
        acc_r = '0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            acc_l = acc_l + 64'(m_coef[k]) * 64'(m_dly_l[k]);
            acc_r = acc_r + 64'(m_coef[k]) * 64'(m_dly_r[k]);
        end
        if (!bypass) begin
            l = acc_l[38:15];                      // truncated slice
            r = acc_r[38:15];
        end
        if (l != '0 || r != '0) begin
            exp_l.push_back(l);
            exp_r.push_back(r);
        end
    endtask

    task automatic clear_decoder();
        dec_lr  = 1'b0;
        dec_cnt = DATA_BITS;                       // wait for first slot edge
        dec_sr  = '0;
        dec_l   = '0;
        rx_l.delete();
        rx_r.delete();
    endtask

    task automatic do_reset();
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        clear_decoder();
        exp_l.delete();
        exp_r.delete();
        for (int k = 0; k < NUM_TAPS; k++) begin
            m_coef[k]  = '0;                       // matches dut reset
            m_dly_l[k] = '0;
            m_dly_r[k] = '0;
        end
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    task automatic load_coefs();
        for (int k = 0; k < NUM_TAPS; k++) begin
            coef_we    <= 1'b1;
            coef_addr  <= CAW'(k);
            coef_wdata <= m_coef[k];
            @(posedge clk);
        end
        coef_we <= 1'b0;
        @(posedge clk);
    endtask

    //////////////////////////////
    // i2s source
    //////////////////////////////
    task automatic send_bit(input chan_e ch, input logic d);
        i2s_bclk  <= 1'b0;                         // data moves on falling bclk
        i2s_lrclk <= (ch == CHAN_RIGHT);
        i2s_d     <= d;
        repeat (in_half) @(posedge clk);
        i2s_bclk  <= 1'b1;
        repeat (in_half) @(posedge clk);
    endtask

    task automatic send_frame(input sample_t l, input sample_t r);
        int   pos;
        logic d;
        for (int b = 0; b < 2 * SLOT_BITS; b++) begin
            pos = b % SLOT_BITS;
            d   = 1'b1;                            // pad bits high, must be ignored
            if (pos >= 1 && pos <= DATA_BITS) begin
                d = (b < SLOT_BITS) ? l[DATA_BITS - pos] : r[DATA_BITS - pos];
            end
            send_bit((b < SLOT_BITS) ? CHAN_LEFT : CHAN_RIGHT, d);
        end
    endtask

    task automatic start_stream();
        send_bit(CHAN_RIGHT, 1'b0);                // gives the receiver a left slot edge
    endtask

    task automatic end_stream();
        send_bit(CHAN_LEFT, 1'b0);                 // closes the last right slot
        i2s_bclk <= 1'b0;
        @(posedge clk);
    endtask

    task automatic play(input sample_t l, input sample_t r);
        model_step(l, r);
        send_frame(l, r);
    endtask

    //////////////////////////////
    // waits
    //////////////////////////////
    task automatic wait_frames(input int n, input int limit);
        int t;
        t = 0;
        while (rx_l.size() < n && t < limit) begin
            @(negedge clk);
            t++;
        end
        if (rx_l.size() < n) begin
            $display("timeout: only %0d of %0d frames decoded", rx_l.size(), n);
            errors++;
        end
        @(posedge clk);
    endtask

    task automatic wait_lr_frames(input int n);
        int   t;
        int   seen;
        logic last;
        t    = 0;
        seen = 0;
        last = dac_lrclk;
        while (seen < n && t < n * 2000) begin
            @(negedge clk);
            if (dac_lrclk && !last) seen++;        // one right slot per frame
            last = dac_lrclk;
            t++;
        end
        if (seen < n) begin
            $display("timeout: dac word clock stopped");
            errors++;
        end
        @(posedge clk);
    endtask

    task automatic settle_and_compare();
        wait_frames(exp_l.size(), 8000);
        wait_lr_frames(2);                         // catch any extra frame
        if (rx_l.size() != exp_l.size()) begin
            $display("decoded %0d frames but expected %0d", rx_l.size(), exp_l.size());
            errors++;
        end
        for (int i = 0; i < exp_l.size() && i < rx_l.size(); i++) begin
            check_sample("dac left", rx_l[i], exp_l[i]);
            check_sample("dac right", rx_r[i], exp_r[i]);
        end
        exp_l.delete();
        exp_r.delete();
        rx_l.delete();
        rx_r.delete();
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic bypass_passthrough();
        sample_t l;
        sample_t r;
        bypass <= 1'b1;
        do_reset();
        start_stream();
        for (int i = 0; i < 8; i++) begin
            lcg_frame(l, r);
            play(l, r);
        end
        end_stream();
        settle_and_compare();
        check_flag("overflow", overflow, 1'b0);
    endtask

    task automatic impulse_and_step();
        bypass <= 1'b0;
        do_reset();
        for (int k = 0; k < NUM_TAPS; k++) begin
            m_coef[k] = coef_t'((k + 1) * 1000);   // distinct per address
        end
        load_coefs();
        start_stream();
        play(24'sh100000, 24'sh080000);            // impulse left, step right
        for (int i = 1; i < NUM_TAPS + 2; i++) begin
            play('0, 24'sh080000);
        end
        end_stream();
        settle_and_compare();
    endtask

    task automatic random_filtering();
        sample_t l;
        sample_t r;
        lcg_coefs();
        load_coefs();
        start_stream();
        for (int i = 0; i < 20; i++) begin
            lcg_frame(l, r);
            play(l, r);
        end
        end_stream();
        settle_and_compare();
    endtask

    task automatic coef_rewrite();
        sample_t l;
        sample_t r;
        lcg_coefs();                               // filter idle, history kept
        load_coefs();
        start_stream();
        for (int i = 0; i < 6; i++) begin
            lcg_frame(l, r);
            play(l, r);
        end
        end_stream();
        settle_and_compare();
    endtask

    task automatic underrun_and_reset();
        wait_lr_frames(4);                         // no input at all
        if (rx_l.size() != 0) begin
            $display("nonzero frame decoded during underrun");
            errors++;
        end
        rst_n <= 1'b0;
        @(negedge clk);
        check_flag("dac_rst", dac_rst, 1'b1);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_flag("dac_bclk", dac_bclk, 1'b0);
        check_flag("dac_lrclk", dac_lrclk, 1'b0);
        check_flag("dac_data", dac_data, 1'b0);
        clear_decoder();
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("dac_rst", dac_rst, 1'b0);
        check_flag("dac_lrclk", dac_lrclk, 1'b0);
        check_flag("dac_data", dac_data, 1'b0);
        @(posedge clk);
    endtask

    task automatic overflow_drop();
        sample_t l;
        sample_t r;
        int      j;
        int      idle;
        int      iter;
        int      n;
        bypass <= 1'b1;                            // output equals input
        do_reset();
        in_half = 1;                               // input faster than dac
        start_stream();
        for (int i = 0; i < 12; i++) begin
            lcg_frame(l, r);
            play(l, r);
        end
        end_stream();
        check_flag("overflow", overflow, 1'b1);
        idle = 0;
        iter = 0;
        while (idle < 3 && iter < 40) begin       // drain until quiet
            n = rx_l.size();
            wait_lr_frames(1);
            idle = (rx_l.size() == n) ? idle + 1 : 0;
            iter++;
        end
        if (rx_l.size() == 0 || rx_l.size() >= exp_l.size()) begin
            $display("expected some but not all frames after overflow, got %0d", rx_l.size());
            errors++;
        end
        j = 0;
        for (int i = 0; i < rx_l.size(); i++) begin
            while (j < exp_l.size() && (exp_l[j] != rx_l[i] || exp_r[j] != rx_r[i])) j++;
            checks++;
            if (j == exp_l.size()) begin
                $display("mismatch dac frame %0d: left %h right %h out of order",
                         i, rx_l[i], rx_r[i]);
                errors++;
                break;
            end
            j++;
        end
        in_half = 3;
        do_reset();
        @(negedge clk);
        check_flag("overflow", overflow, 1'b0);    // reset clears sticky flag
        @(posedge clk);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        rst_n      <= 1'b0;
        bypass     <= 1'b0;
        i2s_bclk   <= 1'b0;
        i2s_lrclk  <= 1'b0;
        i2s_d      <= 1'b0;
        coef_we    <= 1'b0;
        coef_addr  <= '0;
        coef_wdata <= '0;
        clear_decoder();
        @(posedge clk);
        bypass_passthrough();
        impulse_and_step();
        random_filtering();
        coef_rewrite();
        underrun_and_reset();
        overflow_drop();
        $display("errors %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/audio_processor.sv */
`timescale 1ns/10ps
`default_nettype none

module audio_processor
    import audio_pkg::*;
#(
    parameter int NUM_TAPS   = 16,
    parameter int FIFO_DEPTH = 4,
    parameter int BCLK_DIV   = 2
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        bypass,
    input  wire                        i2s_bclk,
    input  wire                        i2s_lrclk,
    input  wire                        i2s_d,
    input  wire                        coef_we,
    input  wire [$clog2(NUM_TAPS)-1:0] coef_addr,
    input  wire coef_t                 coef_wdata,
    output logic                       dac_rst,
    output logic                       dac_bclk,
    output logic                       dac_lrclk,
    output logic                       dac_data,
    output logic                       overflow
);

    logic    push;                                 // rx frame strobe
    sample_t l_in;
    sample_t r_in;

    pcm_frame_if fifo_to_fir ();
    pcm_frame_if fir_to_tx ();

    assign dac_rst = ~rst_n;                       // dac reset is active high

    //////////////////////////////
    // audio chain
    //////////////////////////////
    i2s_receiver u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .i2s_bclk  (i2s_bclk),
        .i2s_lrclk (i2s_lrclk),
        .i2s_d     (i2s_d),
        .push      (push),
        .l_in      (l_in),
        .r_in      (r_in)
    );

    frame_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .l_in     (l_in),
        .r_in     (r_in),
        .overflow (overflow),
        .rd       (fifo_to_fir.source)
    );

    fir_filter #(.NUM_TAPS(NUM_TAPS)) u_fir (
        .clk        (clk),
        .rst_n      (rst_n),
        .bypass     (bypass),
        .coef_we    (coef_we),
        .coef_addr  (coef_addr),
        .coef_wdata (coef_wdata),
        .src        (fifo_to_fir.sink),
        .dst        (fir_to_tx.source)
    );

    i2s_transmitter #(.BCLK_DIV(BCLK_DIV)) u_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .src       (fir_to_tx.sink),
        .dac_bclk  (dac_bclk),
        .dac_lrclk (dac_lrclk),
        .dac_data  (dac_data)
    );

endmodule

`default_nettype wire

/* hw/i2s_transmitter.sv */
`timescale 1ns/10ps
`default_nettype none

module i2s_transmitter
    import audio_pkg::*;
    import i2s_pkg::*;
#(
    parameter int BCLK_DIV = 2                     // bclk half period in clk
) (
    input  wire       clk,
    input  wire       rst_n,
    pcm_frame_if.sink src,
    output logic      dac_bclk,
    output logic      dac_lrclk,
    output logic      dac_data
);

    localparam int FRAME_BITS = 2 * SLOT_BITS;     // 64 bclk per frame
    localparam int CW         = $clog2(FRAME_BITS);
    localparam int DW         = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
    localparam int PAD_BITS   = SLOT_BITS - DATA_BITS;

    logic [DW-1:0]         div_cnt;
    logic                  tick;                   // bclk toggles
    logic                  fall;                   // bclk about to fall
    logic [CW-1:0]         bit_cnt;                // current bit position
    logic [CW-1:0]         nxt_pos;
    chan_e                 slot;
    logic [FRAME_BITS-1:0] sr;                     // output shifter
    sample_t               l_nxt;                  // frame queued for next period
    sample_t               r_nxt;

    assign tick    = (div_cnt == DW'(BCLK_DIV - 1));
    assign fall    = tick & dac_bclk;
    assign nxt_pos = bit_cnt + 1'b1;               // wraps 63 to 0
    assign slot    = chan_e'(nxt_pos[CW-1]);

    // one bit before the left slot
    assign src.take = fall & (bit_cnt == CW'(FRAME_BITS - 2)) & src.avail;

    //////////////////////////////
    // clocks and output bit
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt   <= '0;
            dac_bclk  <= 1'b0;
            bit_cnt   <= '1;                       // first fall starts left slot
            dac_lrclk <= 1'b0;
            dac_data  <= 1'b0;
            l_nxt     <= '0;                       // first frame is silence
            r_nxt     <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) dac_bclk <= ~dac_bclk;
            if (fall) begin
                bit_cnt   <= nxt_pos;
                dac_lrclk <= (slot == CHAN_RIGHT);
                dac_data  <= (nxt_pos == '0) ? 1'b0 : sr[FRAME_BITS-1];
            end
            if (fall && bit_cnt == CW'(FRAME_BITS - 2)) begin
                l_nxt <= src.avail ? src.l_sample : '0;  // zeros on underrun
                r_nxt <= src.avail ? src.r_sample : '0;
            end
        end
    end

    // msb lands one bclk after lrclk edge
    always_ff @(posedge clk) begin
        if (fall) begin
            if (nxt_pos == '0) begin
                sr <= {l_nxt, {PAD_BITS{1'b0}}, r_nxt, {PAD_BITS{1'b0}}};
            end else begin
                sr <= {sr[FRAME_BITS-2:0], 1'b0};
            end
        end
    end

    a_lrclk_on_fall : assert property (@(posedge clk) disable iff (!rst_n)
        $changed(dac_lrclk) |-> $fell(dac_bclk));

endmodule

`default_nettype wire

/* hw/fir_filter.sv */
`timescale 1ns/10ps
`default_nettype none

module fir_filter
    import audio_pkg::*;
#(
    parameter int NUM_TAPS = 16
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        bypass,
    input  wire                        coef_we,
    input  wire [$clog2(NUM_TAPS)-1:0] coef_addr,
    input  wire coef_t                 coef_wdata,
    pcm_frame_if.sink                  src,
    pcm_frame_if.source                dst
);

    localparam int AW = $clog2(NUM_TAPS);

    typedef enum logic [1:0] {ST_IDLE, ST_MAC_L, ST_MAC_R, ST_HOLD} state_e;

    state_e        state;
    coef_t         coef_mem [NUM_TAPS];
    sample_t       dly_l [NUM_TAPS];               // dly[k] is k frames back
    sample_t       dly_r [NUM_TAPS];
    logic [AW-1:0] tap;
    logic          a_vld, a_first, a_last, a_right; // operand fetch stage
    coef_t         a_coef;
    sample_t       a_smp;
    logic          b_vld, b_first, b_last, b_right; // multiply stage
    acc_t          b_prod;
    logic          c_last, c_right;                // accumulate stage
    acc_t          acc;
    sample_t       l_res;
    sample_t       r_res;
    logic          res_vld;
    logic          busy;

    assign src.take     = (state == ST_IDLE) & src.avail;
    assign dst.avail    = res_vld;
    assign dst.l_sample = l_res;
    assign dst.r_sample = r_res;
    assign busy = (state == ST_MAC_L) | (state == ST_MAC_R) | a_vld | b_vld | c_last;

    //////////////////////////////
    // coefficients and delay lines
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                coef_mem[i] <= '0;
                dly_l[i]    <= '0;
                dly_r[i]    <= '0;
            end
        end else begin
            if (coef_we) coef_mem[coef_addr] <= coef_wdata;
            if (src.take) begin                    // advances in bypass too
                dly_l[0] <= src.l_sample;
                dly_r[0] <= src.r_sample;
                for (int i = 1; i < NUM_TAPS; i++) begin
                    dly_l[i] <= dly_l[i-1];
                    dly_r[i] <= dly_r[i-1];
                end
            end
        end
    end

    //////////////////////////////
    // fsm and pipeline valids
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            tap     <= '0;
            a_vld   <= 1'b0;
            b_vld   <= 1'b0;
            c_last  <= 1'b0;
            res_vld <= 1'b0;
        end else begin
            a_vld  <= (state == ST_MAC_L) | (state == ST_MAC_R);
            b_vld  <= a_vld;
            c_last <= b_vld & b_last;
            case (state)
                ST_IDLE: begin
                    tap <= '0;
                    if (src.take) begin
                        state   <= bypass ? ST_HOLD : ST_MAC_L;
                        res_vld <= bypass;         // bypass result next cycle
                    end
                end
                ST_MAC_L, ST_MAC_R: begin
                    tap <= tap + 1'b1;
                    if (tap == AW'(NUM_TAPS - 1)) begin
                        state <= (state == ST_MAC_L) ? ST_MAC_R : ST_HOLD;
                    end
                end
                default: begin                     // hold until tx consumes
                    if (c_last && c_right) res_vld <= 1'b1;
                    if (dst.take) begin
                        res_vld <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    //////////////////////////////
    // mac datapath
    //////////////////////////////
    always_ff @(posedge clk) begin
        a_first <= (tap == '0);
        a_last  <= (tap == AW'(NUM_TAPS - 1));
        a_right <= (state == ST_MAC_R);
        a_coef  <= coef_mem[tap];
        a_smp   <= (state == ST_MAC_R) ? dly_r[tap] : dly_l[tap];
        b_first <= a_first;
        b_last  <= a_last;
        b_right <= a_right;
        b_prod  <= a_coef * a_smp;                 // signed, sign extended to 48
        c_right <= b_right;
        if (b_vld) acc <= b_first ? b_prod : acc + b_prod;
        if (state == ST_IDLE && src.take && bypass) begin
            l_res <= src.l_sample;                 // straight copy
            r_res <= src.r_sample;
        end else if (c_last) begin
            if (c_right) r_res <= acc[OUT_LSB +: $bits(sample_t)];
            else         l_res <= acc[OUT_LSB +: $bits(sample_t)];
        end
    end

    a_coef_idle : assert property (@(posedge clk) disable iff (!rst_n)
        coef_we |-> !busy);

endmodule

`default_nettype wire

/* hw/frame_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_fifo
    import audio_pkg::*;
#(
    parameter int FIFO_DEPTH = 4                   // power of two
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         push,
    input  wire sample_t l_in,
    input  wire sample_t r_in,
    output logic        overflow,                  // sticky until reset
    pcm_frame_if.source rd
);

    localparam int AW = $clog2(FIFO_DEPTH);

    sample_t       l_mem [FIFO_DEPTH];
    sample_t       r_mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;                          // fill level
    logic          full;
    logic          wr_en;
    logic          rd_en;

    assign full  = (count == (AW+1)'(FIFO_DEPTH));
    assign rd_en = rd.take & rd.avail;
    assign wr_en = push & (~full | rd_en);         // full + take frees a slot

    // show-ahead head frame
    assign rd.avail    = (count != '0);
    assign rd.l_sample = l_mem[rd_ptr];
    assign rd.r_sample = r_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            l_mem[wr_ptr] <= l_in;
            r_mem[wr_ptr] <= r_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;    // natural wrap
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && !wr_en) overflow <= 1'b1;  // frame dropped
        end
    end

    a_take_avail : assert property (@(posedge clk) disable iff (!rst_n)
        rd.take |-> rd.avail);

    a_count_max : assert property (@(posedge clk) disable iff (!rst_n)
        count <= FIFO_DEPTH);

endmodule

`default_nettype wire

/* hw/i2s_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module i2s_receiver
    import audio_pkg::*;
    import i2s_pkg::*;
(
    input  wire     clk,
    input  wire     rst_n,
    input  wire     i2s_bclk,                      // async bit clock
    input  wire     i2s_lrclk,                     // async word clock
    input  wire     i2s_d,                         // async serial data
    output logic    push,                          // one pulse per stereo frame
    output sample_t l_in,
    output sample_t r_in
);

    logic [2:0]                   bclk_sync;       // 2 sync flops + edge history
    logic [1:0]                   lr_sync;
    logic [1:0]                   d_sync;
    logic                         bclk_rise;
    chan_e                        lr_now;          // word clock at this bit
    chan_e                        lr_prev;         // word clock at previous bit
    logic [$clog2(SLOT_BITS)-1:0] bit_cnt;         // data bits seen in slot
    sample_t                      shreg;           // deserializer
    sample_t                      l_hold;          // left slot parked until frame end

    //////////////////////////////
    // synchronizer
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bclk_sync <= '0;
            lr_sync   <= '0;
            d_sync    <= '0;
        end else begin
            bclk_sync <= {bclk_sync[1:0], i2s_bclk};
            lr_sync   <= {lr_sync[0], i2s_lrclk};
            d_sync    <= {d_sync[0], i2s_d};
        end
    end

    assign bclk_rise = bclk_sync[1] & ~bclk_sync[2];  // sample point
    assign lr_now    = chan_e'(lr_sync[1]);

    //////////////////////////////
    // slot tracking
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lr_prev <= CHAN_LEFT;
            bit_cnt <= '0;
            push    <= 1'b0;
        end else begin
            push <= 1'b0;
            if (bclk_rise) begin
                lr_prev <= lr_now;
                if (lr_now != lr_prev) begin       // new slot, msb on next bit
                    bit_cnt <= '0;
                    if (lr_prev == CHAN_RIGHT && bit_cnt == DATA_BITS) begin
                        push <= 1'b1;              // full right slot done
                    end
                end else if (bit_cnt < DATA_BITS) begin
                    bit_cnt <= bit_cnt + 1'b1;     // pad bits not counted
                end
            end
        end
    end

    // data path, no reset
    always_ff @(posedge clk) begin
        if (bclk_rise) begin
            if (lr_now != lr_prev) begin
                if (lr_prev == CHAN_LEFT) begin
                    l_hold <= shreg;
                end else begin
                    l_in <= l_hold;                // frame out with push
                    r_in <= shreg;
                end
            end else if (bit_cnt < DATA_BITS) begin
                shreg <= {shreg[DATA_BITS-2:0], d_sync[1]};  // msb first
            end
        end
    end

    a_push_single : assert property (@(posedge clk) disable iff (!rst_n)
        push |=> !push);

endmodule

`default_nettype wire

/* hw/pcm_frame_if.sv */
`timescale 1ns/10ps
`default_nettype none

// one stereo frame per take, avail stays up until consumed
interface pcm_frame_if
    import audio_pkg::*;
();
    sample_t l_sample;                             // left channel
    sample_t r_sample;                             // right channel
    logic    avail;                                // frame valid and stable
    logic    take;                                 // one-cycle consume strobe

    modport source (
        output l_sample,
        output r_sample,
        output avail,
        input  take
    );

    modport sink (
        input  l_sample,
        input  r_sample,
        input  avail,
        output take
    );

endinterface

`default_nettype wire

/* hw/i2s_pkg.sv */
`default_nettype none

package i2s_pkg;

    //////////////////////////////
    // i2s frame format
    //////////////////////////////
    localparam int SLOT_BITS = 32;                 // bit clocks per channel slot
    localparam int DATA_BITS = 24;                 // significant bits, msb first

    // word clock level per channel
    typedef enum logic {
        CHAN_LEFT  = 1'b0,                         // lrclk low
        CHAN_RIGHT = 1'b1                          // lrclk high
    } chan_e;

endpackage

`default_nettype wire

/* hw/audio_pkg.sv */
`default_nettype none

package audio_pkg;

    //////////////////////////////
    // pcm datapath widths
    //////////////////////////////
    typedef logic signed [23:0] sample_t;          // one pcm sample
    typedef logic signed [15:0] coef_t;            // fir coefficient, q1.15
    typedef logic signed [47:0] acc_t;             // mac accumulator

    // output sample is acc[38:15], plain truncation
    localparam int OUT_LSB = 15;                   // lowest acc bit kept

endpackage

`default_nettype wire
